/* verilog/pm_settings.svh */
// sizes for the packet memory datapath and queues
// included by the package and by any RTL file that sizes ports
`ifndef PM_SETTINGS_SVH
`define PM_SETTINGS_SVH

// ----------------------------------------
// data and codeword
// ----------------------------------------
`define PM_DATA_W 32
`define PM_ADDR_W 8

// 32 data bits, 6 hamming bits, 1 overall parity bit
`define PM_CODE_W 39

// ----------------------------------------
// banks, queue and retiming
// ----------------------------------------
// even addresses in bank 0, odd addresses in bank 1
`define PM_N_BANKS 2

// result queue depth, also the credit count on both sides
`define PM_RD_CREDITS 4

`define PM_IN_STAGES 1

`endif

/* verilog/pm_pkg.sv */
// request, codeword and result types for the packet memory
// also holds the SEC-DED bit placement used by encoder and checker
`include "pm_settings.svh"

package pm_pkg;

  localparam int PM_SYN_W  = `PM_CODE_W - `PM_DATA_W - 1;
  localparam int PM_BANK_W = $clog2(`PM_N_BANKS);
  localparam int PM_ROW_W  = `PM_ADDR_W - PM_BANK_W;

  typedef logic [`PM_CODE_W-1:0] pm_code_t;

  typedef struct packed {
    logic                  valid;
    logic [`PM_ADDR_W-1:0] addr;
    logic [`PM_DATA_W-1:0] data;
    logic [1:0]            err_inj;
  } pm_wr_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`PM_ADDR_W-1:0] addr;
  } pm_rd_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`PM_ADDR_W-1:0] addr;
    pm_code_t              code;
  } pm_wr_code_t;

  typedef enum logic [1:0] {
    PM_OK            = 2'd0,
    PM_CORRECTED     = 2'd1,
    PM_UNCORRECTABLE = 2'd2
  } pm_status_e;

  typedef struct packed {
    logic [`PM_ADDR_W-1:0] addr;
    logic [`PM_DATA_W-1:0] data;
    pm_status_e            status;
  } pm_rd_result_t;

  // ----------------------------------------
  // codeword layout
  // ----------------------------------------
  // bit 0 is overall parity, powers of two hold hamming bits,
  // data fills the remaining positions in ascending order
  function automatic pm_code_t pm_place_data(input logic [`PM_DATA_W-1:0] data);
    pm_code_t code;
    int       d;
    code = '0;
    d    = 0;
    for (int pos = 1; pos < `PM_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        code[pos] = data[d];
        d++;
      end
    end
    return code;
  endfunction

  function automatic logic [`PM_DATA_W-1:0] pm_extract_data(input pm_code_t code);
    logic [`PM_DATA_W-1:0] data;
    int                    d;
    data = '0;
    d    = 0;
    for (int pos = 1; pos < `PM_CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data[d] = code[pos];
        d++;
      end
    end
    return data;
  endfunction

  // xor of the positions of all set bits, parity bit excluded
  function automatic logic [PM_SYN_W-1:0] pm_syndrome(input pm_code_t code);
    logic [PM_SYN_W-1:0] syn;
    syn = '0;
    for (int pos = 1; pos < `PM_CODE_W; pos++) begin
      if (code[pos]) begin
        syn ^= PM_SYN_W'(pos);
      end
    end
    return syn;
  endfunction

endpackage

/* verilog/pm_bank_if.sv */
// read return of one memory bank toward the ECC checker
// one instance per bank, bank side drives and checker side samples
`timescale 1ns/1ps

interface pm_bank_if import pm_pkg::*; ();

  logic                 rd_valid;
  // row inside the bank, bank id restores the low address bits
  logic [PM_ROW_W-1:0]  rd_addr;
  pm_code_t             rd_code;
  logic [PM_BANK_W-1:0] rd_bank_id;

  modport bank (
    output rd_valid,
    output rd_addr,
    output rd_code,
    output rd_bank_id
  );

  modport check (
    input rd_valid,
    input rd_addr,
    input rd_code,
    input rd_bank_id
  );

endinterface

/* verilog/pm_delay.sv */
// reset-cleared register pipeline for any payload type
// used to retime the write and read request ports
`timescale 1ns/1ps

module pm_delay #(
  parameter type T      = logic,
  parameter int  STAGES = 1
) (
  input  logic clk,
  input  logic i_arst_n,
  input  T     i_in,
  output T     o_out
);

  T stage_q [STAGES];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      // zero payload keeps the valid bits inactive
      for (int s = 0; s < STAGES; s++) begin
        stage_q[s] <= '0;
      end
    end else begin
      stage_q[0] <= i_in;
      for (int s = 1; s < STAGES; s++) begin
        stage_q[s] <= stage_q[s-1];
      end
    end
  end

  assign o_out = stage_q[STAGES-1];

endmodule

/* verilog/pm_encode_ecc.sv */
// SEC-DED encoder on the write path, with test error injection
// its codeword is broadcast to every bank
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_encode_ecc import pm_pkg::*; (
  input  pm_wr_req_t  i_wr,
  output pm_wr_code_t o_wr_code
);

  pm_code_t              clean_code;
  logic [PM_SYN_W-1:0]   check_bits;
  logic [`PM_DATA_W-1:0] inj_mask;

  // ----------------------------------------
  // check bits
  // ----------------------------------------
  always_comb begin
    clean_code = pm_place_data(i_wr.data);
    // with hamming slots still zero the syndrome equals the check bits
    check_bits = pm_syndrome(clean_code);
    for (int k = 0; k < PM_SYN_W; k++) begin
      clean_code[1 << k] = check_bits[k];
    end
    // overall parity makes the full codeword even
    clean_code[0] = ^clean_code[`PM_CODE_W-1:1];
  end

  // ----------------------------------------
  // error injection
  // ----------------------------------------
  // 1 flips data bit 0, 2 flips data bits 0 and 1
  always_comb begin
    case (i_wr.err_inj)
      2'd1:    inj_mask = `PM_DATA_W'(1);
      2'd2:    inj_mask = `PM_DATA_W'(3);
      default: inj_mask = '0;
    endcase
  end

  assign o_wr_code.valid = i_wr.valid;
  assign o_wr_code.addr  = i_wr.addr;
  // mask goes through the same placement so it lands on data positions
  assign o_wr_code.code  = clean_code ^ pm_place_data(inj_mask);

endmodule

/* verilog/pm_bank.sv */
// one memory bank holding the addresses whose low bits match BANK_ID
// writes in place, returns a registered codeword one cycle after a read
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_bank import pm_pkg::*; #(
  parameter int BANK_ID = 0
) (
  input  logic        clk,
  input  logic        i_arst_n,
  input  pm_wr_code_t i_wr_code,
  input  pm_rd_req_t  i_rd_req,
  pm_bank_if.bank     bank_if
);

  pm_code_t            mem [2**PM_ROW_W];
  logic                wr_hit;
  logic                rd_hit;
  logic [PM_ROW_W-1:0] wr_row;
  logic [PM_ROW_W-1:0] rd_row;

  // address decode, each bank picks out its own share
  assign wr_hit = i_wr_code.valid &&
                  (i_wr_code.addr[PM_BANK_W-1:0] == PM_BANK_W'(BANK_ID));
  assign rd_hit = i_rd_req.valid &&
                  (i_rd_req.addr[PM_BANK_W-1:0] == PM_BANK_W'(BANK_ID));
  assign wr_row = i_wr_code.addr[`PM_ADDR_W-1:PM_BANK_W];
  assign rd_row = i_rd_req.addr[`PM_ADDR_W-1:PM_BANK_W];

  // ----------------------------------------
  // array and read data
  // ----------------------------------------
  // a read in the same cycle as a write to its row sees the old word
  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem[wr_row] <= i_wr_code.code;
    end
    if (rd_hit) begin
      bank_if.rd_addr <= rd_row;
      bank_if.rd_code <= mem[rd_row];
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      bank_if.rd_valid <= 1'b0;
    end else begin
      bank_if.rd_valid <= rd_hit;
    end
  end

  assign bank_if.rd_bank_id = PM_BANK_W'(BANK_ID);

endmodule

/* verilog/pm_check_ecc.sv */
// read-side checker: merges bank returns, corrects, queues results
// runs consumer credits and returns requester credits as results leave
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_check_ecc import pm_pkg::*; (
  input  logic          clk,
  input  logic          i_arst_n,
  pm_bank_if.check      bank0_if,
  pm_bank_if.check      bank1_if,
  input  logic          i_rd_credit,
  output logic          o_req_credit,
  output logic          o_result_valid,
  output pm_rd_result_t o_result
);

  localparam int PTR_W = $clog2(`PM_RD_CREDITS);
  localparam int CNT_W = $clog2(`PM_RD_CREDITS + 1);

  logic                 ret_valid;
  logic [PM_ROW_W-1:0]  ret_row;
  logic [PM_BANK_W-1:0] ret_bank;
  pm_code_t             ret_code;
  logic [PM_SYN_W-1:0]  syn;
  logic                 par_err;
  pm_code_t             fix_code;
  pm_rd_result_t        chk_result;

  pm_rd_result_t        queue_mem [`PM_RD_CREDITS];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     q_count;
  logic [CNT_W-1:0]     cons_credits;
  logic                 issue;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(`PM_RD_CREDITS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ----------------------------------------
  // bank merge and SEC-DED check
  // ----------------------------------------
  // banks never return in the same cycle
  assign ret_valid = bank0_if.rd_valid | bank1_if.rd_valid;
  assign ret_row   = bank1_if.rd_valid ? bank1_if.rd_addr    : bank0_if.rd_addr;
  assign ret_bank  = bank1_if.rd_valid ? bank1_if.rd_bank_id : bank0_if.rd_bank_id;
  assign ret_code  = bank1_if.rd_valid ? bank1_if.rd_code    : bank0_if.rd_code;

  always_comb begin
    syn             = pm_syndrome(ret_code);
    par_err         = ^ret_code;
    fix_code        = ret_code;
    chk_result.addr = {ret_row, ret_bank};
    if (par_err && (int'(syn) < `PM_CODE_W)) begin
      // single flip, syndrome 0 means the parity bit itself
      fix_code[syn]     = ~ret_code[syn];
      chk_result.status = PM_CORRECTED;
    end else if (par_err || (syn != '0)) begin
      chk_result.status = PM_UNCORRECTABLE;
    end else begin
      chk_result.status = PM_OK;
    end
    chk_result.data = pm_extract_data(fix_code);
  end

  // ----------------------------------------
  // result queue and credits
  // ----------------------------------------
  assign issue = (q_count != '0) && (cons_credits != '0);

  always_ff @(posedge clk) begin
    if (ret_valid) begin
      queue_mem[wr_ptr] <= chk_result;
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      q_count      <= '0;
      cons_credits <= CNT_W'(`PM_RD_CREDITS);
    end else begin
      if (ret_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (issue) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      q_count      <= q_count + CNT_W'(ret_valid) - CNT_W'(issue);
      cons_credits <= cons_credits + CNT_W'(i_rd_credit) - CNT_W'(issue);
    end
  end

  assign o_result_valid = issue;
  assign o_result       = queue_mem[rd_ptr];
  // each result leaving frees one read slot upstream
  assign o_req_credit   = issue;

endmodule

/* verilog/pm_top.sv */
// packet memory top: scheduler write and read ports in, checked results out
// results toward the modify side are flow controlled by credits
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_top import pm_pkg::*; (
  input  logic                  clk,
  input  logic                  i_arst_n,

  // write port
  input  logic                  i_wr_valid,
  input  logic [`PM_ADDR_W-1:0] i_wr_addr,
  input  logic [`PM_DATA_W-1:0] i_wr_data,
  input  logic [1:0]            i_wr_err_inj,

  // read request port
  input  logic                  i_rd_valid,
  input  logic [`PM_ADDR_W-1:0] i_rd_addr,

  // result port toward the consumer
  input  logic                  i_rd_credit,
  output logic                  o_req_credit,
  output logic                  o_rd_valid,
  output logic [`PM_ADDR_W-1:0] o_rd_addr,
  output logic [`PM_DATA_W-1:0] o_rd_data,
  output pm_status_e            o_rd_status
);

  pm_wr_req_t    wr_req;
  pm_wr_req_t    wr_req_dly;
  pm_rd_req_t    rd_req;
  pm_rd_req_t    rd_req_dly;
  pm_wr_code_t   wr_code;
  pm_rd_result_t rd_result;

  pm_bank_if bank0_if ();
  pm_bank_if bank1_if ();

  // ----------------------------------------
  // input retiming
  // ----------------------------------------
  assign wr_req = '{valid: i_wr_valid, addr: i_wr_addr, data: i_wr_data,
                    err_inj: i_wr_err_inj};
  assign rd_req = '{valid: i_rd_valid, addr: i_rd_addr};

  pm_delay #(
    .T      ( pm_wr_req_t   ),
    .STAGES ( `PM_IN_STAGES )
  ) u_delay_wr (
    .clk      ( clk        ),
    .i_arst_n ( i_arst_n   ),
    .i_in     ( wr_req     ),
    .o_out    ( wr_req_dly )
  );

  pm_delay #(
    .T      ( pm_rd_req_t   ),
    .STAGES ( `PM_IN_STAGES )
  ) u_delay_rd (
    .clk      ( clk        ),
    .i_arst_n ( i_arst_n   ),
    .i_in     ( rd_req     ),
    .o_out    ( rd_req_dly )
  );

  pm_encode_ecc u_encode_ecc (
    .i_wr      ( wr_req_dly ),
    .o_wr_code ( wr_code    )
  );

  // ----------------------------------------
  // banks
  // ----------------------------------------
  pm_bank #(.BANK_ID(0)) u_bank0 (
    .clk       ( clk        ),
    .i_arst_n  ( i_arst_n   ),
    .i_wr_code ( wr_code    ),
    .i_rd_req  ( rd_req_dly ),
    .bank_if   ( bank0_if   )
  );

  pm_bank #(.BANK_ID(1)) u_bank1 (
    .clk       ( clk        ),
    .i_arst_n  ( i_arst_n   ),
    .i_wr_code ( wr_code    ),
    .i_rd_req  ( rd_req_dly ),
    .bank_if   ( bank1_if   )
  );

  pm_check_ecc u_check_ecc (
    .clk            ( clk          ),
    .i_arst_n       ( i_arst_n     ),
    .bank0_if       ( bank0_if     ),
    .bank1_if       ( bank1_if     ),
    .i_rd_credit    ( i_rd_credit  ),
    .o_req_credit   ( o_req_credit ),
    .o_result_valid ( o_rd_valid   ),
    .o_result       ( rd_result    )
  );

  assign o_rd_addr   = rd_result.addr;
  assign o_rd_data   = rd_result.data;
  assign o_rd_status = rd_result.status;

endmodule

/* tests/pm_properties.sv */
// credit and queue rules of the read-side checker as concurrent assertions
// bound into every pm_check_ecc instance
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_properties #(
  parameter int CNT_W = $clog2(`PM_RD_CREDITS + 1)
) (
  input logic             clk,
  input logic             i_arst_n,
  input logic             i_issue,
  input logic             i_rd_credit,
  input logic [CNT_W-1:0] i_q_count,
  input logic             i_req_credit
);

  // failure count, read by the testbench at the end of the run
  int unsigned n_failures = 0;

  // consumer credits rebuilt from the port pulses
  int port_credits;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      port_credits <= `PM_RD_CREDITS;
    end else begin
      port_credits <= port_credits + int'(i_rd_credit) - int'(i_issue);
    end
  end

  a_issue_needs_credit: assert property (
    @(posedge clk) disable iff (!i_arst_n) i_issue |-> (port_credits > 0)
  ) else begin
    n_failures++;
    $error("result issued with no consumer credit left");
  end

  a_queue_bound: assert property (
    @(posedge clk) disable iff (!i_arst_n) i_q_count <= CNT_W'(`PM_RD_CREDITS)
  ) else begin
    n_failures++;
    $error("result queue holds more entries than its depth");
  end

  a_credit_quiet_in_reset: assert property (
    @(posedge clk) !i_arst_n |-> !i_req_credit
  ) else begin
    n_failures++;
    $error("requester credit pulsed while reset is active");
  end

endmodule

bind pm_check_ecc pm_properties u_properties (
  .clk          ( clk            ),
  .i_arst_n     ( i_arst_n       ),
  .i_issue      ( o_result_valid ),
  .i_rd_credit  ( i_rd_credit    ),
  .i_q_count    ( q_count        ),
  .i_req_credit ( o_req_credit   )
);

/* tests/pm_tb.sv */
// table-driven testbench for the packet memory top level
// runs a directed table, then LCG traffic, checking results in order
`timescale 1ns/1ps
`include "pm_settings.svh"

module pm_tb import pm_pkg::*; ();

  localparam int CLK_PERIOD = 10;
  localparam int N_TABLE    = 28;
  localparam int N_RAND     = 80;

  typedef enum logic [2:0] {OP_IDLE, OP_WR, OP_WR_RND, OP_RD, OP_HOLD, OP_GIVE} op_e;

  typedef struct packed {
    op_e                   op;
    logic [`PM_ADDR_W-1:0] addr;
    logic [`PM_DATA_W-1:0] data;
    logic [1:0]            inj;
    pm_status_e            exp;
  } stim_t;

  logic                  clk;
  logic                  i_arst_n;
  logic                  i_wr_valid;
  logic [`PM_ADDR_W-1:0] i_wr_addr;
  logic [`PM_DATA_W-1:0] i_wr_data;
  logic [1:0]            i_wr_err_inj;
  logic                  i_rd_valid;
  logic [`PM_ADDR_W-1:0] i_rd_addr;
  logic                  i_rd_credit;
  logic                  o_req_credit;
  logic                  o_rd_valid;
  logic [`PM_ADDR_W-1:0] o_rd_addr;
  logic [`PM_DATA_W-1:0] o_rd_data;
  pm_status_e            o_rd_status;

  // reference model of the memory contents
  logic [`PM_DATA_W-1:0] ref_data [2**`PM_ADDR_W];
  pm_status_e            ref_status [2**`PM_ADDR_W];
  bit                    ref_valid [2**`PM_ADDR_W];
  logic [`PM_ADDR_W-1:0] last_wr_addr;

  pm_rd_result_t exp_q [$];
  string         name_q [$];
  int            req_credits     = `PM_RD_CREDITS;
  int            n_granted       = `PM_RD_CREDITS;
  int            n_delivered     = 0;
  int            pending_returns = 0;
  bit            hold_credits    = 1'b0;
  bit            give_credit     = 1'b0;
  logic [31:0]   lcg_state       = 32'd55570;

  // ----------------------------------------
  // stimulus table
  // ----------------------------------------
  // op, address, data, injection, expected status
  stim_t stim [N_TABLE] = '{
    '{OP_IDLE,   8'h00, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_WR,     8'h10, 32'hdead_beef, 2'd0, PM_OK},
    '{OP_WR,     8'h11, 32'h1234_5678, 2'd0, PM_OK},
    '{OP_RD,     8'h10, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h11, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_WR,     8'h10, 32'hcafe_f00d, 2'd0, PM_OK},
    '{OP_RD,     8'h10, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_WR_RND, 8'h20, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_WR_RND, 8'h21, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h21, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h20, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_WR,     8'h30, 32'ha5a5_a5a5, 2'd1, PM_CORRECTED},
    '{OP_RD,     8'h30, 32'h0000_0000, 2'd0, PM_CORRECTED},
    '{OP_WR,     8'h31, 32'h0f0f_0f0f, 2'd2, PM_UNCORRECTABLE},
    '{OP_RD,     8'h31, 32'h0000_0000, 2'd0, PM_UNCORRECTABLE},
    '{OP_IDLE,   8'h00, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_HOLD,   8'h00, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h10, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h11, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h20, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h21, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h30, 32'h0000_0000, 2'd0, PM_CORRECTED},
    '{OP_RD,     8'h31, 32'h0000_0000, 2'd0, PM_UNCORRECTABLE},
    '{OP_RD,     8'h10, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_RD,     8'h11, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_IDLE,   8'h00, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_GIVE,   8'h00, 32'h0000_0000, 2'd0, PM_OK},
    '{OP_IDLE,   8'h00, 32'h0000_0000, 2'd0, PM_OK}
  };

  pm_top UUT (
    .clk          ( clk          ),
    .i_arst_n     ( i_arst_n     ),
    .i_wr_valid   ( i_wr_valid   ),
    .i_wr_addr    ( i_wr_addr    ),
    .i_wr_data    ( i_wr_data    ),
    .i_wr_err_inj ( i_wr_err_inj ),
    .i_rd_valid   ( i_rd_valid   ),
    .i_rd_addr    ( i_rd_addr    ),
    .i_rd_credit  ( i_rd_credit  ),
    .o_req_credit ( o_req_credit ),
    .o_rd_valid   ( o_rd_valid   ),
    .o_rd_addr    ( o_rd_addr    ),
    .o_rd_data    ( o_rd_data    ),
    .o_rd_status  ( o_rd_status  )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // helpers and compare tasks
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pm_status_e status_for_inj(input logic [1:0] inj);
    case (inj)
      2'd1:    return PM_CORRECTED;
      2'd2:    return PM_UNCORRECTABLE;
      default: return PM_OK;
    endcase
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input string name, input pm_rd_result_t exp,
                              input pm_rd_result_t act);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s expected %h/%h/%s actual %h/%h/%s",
                               name, exp.addr, exp.data, exp.status.name(),
                               act.addr, act.data, act.status.name()));
    end
  endtask

  // delivered results may never outrun consumer credits granted
  task automatic check_credits(input string name, input int delivered, input int granted);
    if (delivered > granted) begin
      report_failure($sformatf("MISMATCH %s expected at most %0d results actual %0d",
                               name, granted, delivered));
    end
  endtask

  task automatic do_write(input logic [`PM_ADDR_W-1:0] addr,
                          input logic [`PM_DATA_W-1:0] data, input logic [1:0] inj);
    ref_data[addr]   = data;
    ref_status[addr] = status_for_inj(inj);
    ref_valid[addr]  = 1'b1;
    last_wr_addr     = addr;
    i_wr_valid   = 1'b1;
    i_wr_addr    = addr;
    i_wr_data    = data;
    i_wr_err_inj = inj;
    @(posedge clk);
    #1;
    i_wr_valid   = 1'b0;
    i_wr_err_inj = 2'd0;
  endtask

  task automatic issue_read(input logic [`PM_ADDR_W-1:0] addr, input pm_status_e st,
                            input string name);
    pm_rd_result_t exp;
    while (req_credits == 0) begin
      @(posedge clk);
      #1;
    end
    exp.addr   = addr;
    exp.status = st;
    // a double flip leaves data bits 0 and 1 inverted
    exp.data   = (st == PM_UNCORRECTABLE) ? ref_data[addr] ^ 32'h3 : ref_data[addr];
    exp_q.push_back(exp);
    name_q.push_back(name);
    req_credits--;
    i_rd_valid = 1'b1;
    i_rd_addr  = addr;
    @(posedge clk);
    #1;
    i_rd_valid = 1'b0;
  endtask

  // ----------------------------------------
  // monitor and consumer credit return
  // ----------------------------------------
  always @(negedge clk) begin
    pm_rd_result_t act;
    string         name;
    if (i_arst_n) begin
      if (o_req_credit !== o_rd_valid) begin
        report_failure("o_req_credit pulse does not line up with a delivered result");
      end
      // read slots come back only through o_req_credit
      if (o_req_credit === 1'b1) begin
        req_credits++;
      end
      if (o_rd_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_failure("a result was delivered with no read outstanding");
        end
        act  = '{addr: o_rd_addr, data: o_rd_data, status: o_rd_status};
        name = name_q.pop_front();
        check_result(name, exp_q.pop_front(), act);
        n_delivered++;
        pending_returns++;
        check_credits(name, n_delivered, n_granted);
      end
      give_credit = !hold_credits && (pending_returns > 0);
      if (give_credit) begin
        pending_returns--;
        n_granted++;
      end
    end
  end

  always @(posedge clk) begin
    #1;
    i_rd_credit = give_credit;
  end

  initial begin : watchdog
    #((N_TABLE + N_RAND) * 20 * CLK_PERIOD + 200 * CLK_PERIOD);
    report_failure("watchdog timeout, the run did not finish in time");
  end

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin : stimulus
    stim_t                 e;
    logic [31:0]           r;
    logic [`PM_ADDR_W-1:0] a;
    i_arst_n     = 1'b0;
    i_wr_valid   = 1'b0;
    i_wr_addr    = '0;
    i_wr_data    = '0;
    i_wr_err_inj = 2'd0;
    i_rd_valid   = 1'b0;
    i_rd_addr    = '0;
    i_rd_credit  = 1'b0;
    last_wr_addr = '0;
    repeat (4) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    for (int i = 0; i < N_TABLE; i++) begin
      e = stim[i];
      case (e.op)
        OP_IDLE: begin
          repeat (10) begin
            @(posedge clk);
            #1;
          end
        end
        OP_WR:     do_write(e.addr, e.data, e.inj);
        OP_WR_RND: do_write(e.addr, lcg_next(), e.inj);
        OP_RD:     issue_read(e.addr, e.exp, $sformatf("table %0d addr %h", i, e.addr));
        OP_HOLD:   hold_credits = 1'b1;
        OP_GIVE: begin
          // all four held reads should still be waiting in the queue
          if (exp_q.size() != `PM_RD_CREDITS) begin
            report_failure("results were delivered while consumer credits were withheld");
          end
          hold_credits = 1'b0;
        end
        default: ;
      endcase
    end

    // random traffic, reads only hit addresses already written
    for (int k = 0; k < N_RAND; k++) begin
      r = lcg_next();
      a = r[23:16];
      if (r[31]) begin
        if (!ref_valid[a]) begin
          a = last_wr_addr;
        end
        issue_read(a, ref_status[a], $sformatf("random %0d addr %h", k, a));
      end else begin
        do_write(a, lcg_next(), 2'd0);
      end
    end

    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    repeat (5) @(posedge clk);
    #1;

    if (UUT.u_check_ecc.u_properties.n_failures != 0) begin
      report_failure("assertions in the result checker failed");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

/* sim.f */
+incdir+verilog
verilog/pm_pkg.sv
verilog/pm_bank_if.sv
verilog/pm_delay.sv
verilog/pm_encode_ecc.sv
verilog/pm_bank.sv
verilog/pm_check_ecc.sv
verilog/pm_top.sv
tests/pm_properties.sv
tests/pm_tb.sv
